// ==== sim.f ====
+incdir+logic
+incdir+testbench
logic/bb_pkg.sv
logic/packet_sequencer.sv
logic/header_codec.sv
logic/header_decoder.sv
logic/baseband_header.sv
testbench/tb_baseband_header.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run with verilator, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 -f sim.f --top-module tb_baseband_header -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "TESTS PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== testbench/tb_header_model.svh ====
`ifndef TB_HEADER_MODEL_SVH
`define TB_HEADER_MODEL_SVH

// 32 bit fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  logic fb;
  fb = s[31] ^ s[21] ^ s[1] ^ s[0];
  return {s[30:0], fb};
endfunction

// hec over the 10 header bits, lsb first, seeded with the uap
function automatic logic [7:0] hec_calc(input logic [7:0] seed, input logic [9:0] hdr);
  logic [7:0] r;
  logic       fb;
  r = seed;
  for (int i = 0; i < 10; i++)
  begin
    fb = r[7] ^ hdr[i];
    r = {r[6:0], 1'b0} ^ (fb ? 8'ha7 : 8'h00);  // D8+D7+D5+D2+D+1
  end
  return r;
endfunction

// whitening sequence for 18 header bits, D7+D4+1
function automatic logic [17:0] whiten_mask(input logic [5:0] seed);
  logic [6:0]  w;
  logic [17:0] m;
  w = {1'b1, seed};
  for (int i = 0; i < 18; i++)
  begin
    m[i] = w[6];
    w = {w[5:0], 1'b0} ^ (w[6] ? 7'h11 : 7'h00);
  end
  return m;
endfunction

// whole packet as it should appear on the line, bit 0 first
function automatic logic [125:0] packet_bits(input logic [63:0] sync, input logic [7:0] uap,
                                             input logic [5:0] seed, input logic wen,
                                             input logic [9:0] hdr);
  logic [125:0] p;
  logic [17:0]  hb;
  logic [17:0]  mask;
  logic [7:0]   h;
  for (int i = 4; i < 68; i++)
    p[i] = sync[i-4];
  for (int i = 3; i >= 0; i--)
    p[i] = ~p[i+1];  // alternates into the sync word
  for (int i = 68; i < 72; i++)
    p[i] = ~p[i-1];  // and back out of it
  h = hec_calc(uap, hdr);
  hb[9:0] = hdr;
  for (int j = 0; j < 8; j++)
    hb[10+j] = h[7-j];  // remainder goes out msb first
  mask = wen ? whiten_mask(seed) : 18'd0;
  for (int t = 0; t < 18; t++)
    for (int r = 0; r < 3; r++)
      p[72 + 3*t + r] = hb[t] ^ mask[t];
  return p;
endfunction

`endif

// ==== testbench/tb_baseband_header.sv ====
module tb_baseband_header
  import bb_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  `include "tb_header_model.svh"

  localparam int n_tests     = 8;
  localparam int cycle_limit = n_tests * 2 * 130 * 6 + 3000;

  logic         clk_6M, rstz, p_1us, tx_start_p, rx_trailer_st_p;
  sync_word_t   sync_word;
  uap_t         uap;
  whiten_seed_t clk_seed;
  logic         whiten_en, tx_flow, tx_arqn, tx_seqn, rx_bit;
  lt_addr_t     tx_lt_addr, my_lt_addr, rx_lt_addr;
  pk_type_t     tx_pk_type, rx_pk_type;
  logic         tx_bit, busy, rx_flow, rx_arqn, rx_seqn, rx_is_poll;
  logic         hec_good, lt_addressed, hdr_done_p;

  logic [31:0]  rng;
  logic [2:0]   div;
  logic [125:0] exp_line, rec, flip;
  logic [9:0]   exp_hdr;
  logic         exp_good, exp_addr, prev_flow, prev_arqn;
  logic         tx_check, line_q, done_due;
  int           tx_pos, errors, tests_run, cycles;
  string        test_name;

  baseband_header DUT (.*);

  initial
  begin
    clk_6M = 1'b0;
    forever #50 clk_6M = ~clk_6M;
  end

  // one tick in six clocks
  always @(posedge clk_6M)
  begin
    div   <= (div == 3'd5) ? 3'd0 : div + 3'd1;
    p_1us <= (div == 3'd4);
  end

  always @(posedge clk_6M)
  begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit)
    begin
      $display("timeout, run still going after %0d cycles", cycle_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  assert property (@(posedge clk_6M) disable iff (!rstz)
    (tx_check && p_1us) |-> (tx_bit == exp_line[tx_pos]))
    else
    begin
      errors++;
      $display("Fail %s line bit %0d expected %0b actual %0b", test_name, $sampled(tx_pos),
               exp_line[$sampled(tx_pos)], $sampled(tx_bit));
    end

  assert property (@(posedge clk_6M) disable iff (!rstz) (tx_check && p_1us) |-> busy)
    else
    begin
      errors++;
      $display("Fail %s busy expected 1 actual %0b", test_name, $sampled(busy));
    end

  // busy drops on the last bit, before the header result comes out
  assert property (@(posedge clk_6M) disable iff (!rstz) hdr_done_p |-> !busy)
    else
    begin
      errors++;
      $display("Fail %s busy expected 0 actual %0b", test_name, $sampled(busy));
    end

  assert property (@(posedge clk_6M) disable iff (!rstz) (done_due && p_1us) |-> hdr_done_p)
    else
    begin
      errors++;
      $display("%s: hdr_done_p did not come one tick after the last header bit", test_name);
    end

  assert property (@(posedge clk_6M) disable iff (!rstz) hdr_done_p |-> done_due)
    else
    begin
      errors++;
      $display("%s: hdr_done_p fired outside its expected tick", test_name);
    end

  assert property (@(posedge clk_6M) disable iff (!rstz) hdr_done_p |-> (hec_good == exp_good))
    else
    begin
      errors++;
      $display("Fail %s hec_good expected %0b actual %0b", test_name, exp_good, hec_good);
    end

  assert property (@(posedge clk_6M) disable iff (!rstz) (hdr_done_p && exp_good) |->
    ({rx_seqn, rx_arqn, rx_flow, rx_pk_type, rx_lt_addr} == exp_hdr))
    else
    begin
      errors++;
      $display("Fail %s fields expected %h actual %h", test_name, exp_hdr,
               {rx_seqn, rx_arqn, rx_flow, rx_pk_type, rx_lt_addr});
    end

  assert property (@(posedge clk_6M) disable iff (!rstz) (hdr_done_p && exp_good) |->
    (rx_is_poll == (exp_hdr[6:3] == 4'd1)))
    else
    begin
      errors++;
      $display("Fail %s rx_is_poll expected %0b actual %0b", test_name,
               exp_hdr[6:3] == 4'd1, rx_is_poll);
    end

  assert property (@(posedge clk_6M) disable iff (!rstz)
    hdr_done_p |-> (lt_addressed == exp_addr))
    else
    begin
      errors++;
      $display("Fail %s lt_addressed expected %0b actual %0b", test_name, exp_addr, lt_addressed);
    end

  // bad hec must not touch flow and arqn
  assert property (@(posedge clk_6M) disable iff (!rstz) (hdr_done_p && !exp_good) |->
    ({rx_flow, rx_arqn} == {prev_flow, prev_arqn}))
    else
    begin
      errors++;
      $display("Fail %s flow,arqn expected %b actual %b", test_name,
               {prev_flow, prev_arqn}, {rx_flow, rx_arqn});
    end

  // returns right after the posedge on which the dut sees p_1us
  task automatic next_tick();
    @(negedge clk_6M);
    while (!p_1us)
      @(negedge clk_6M);
    line_q = tx_bit;
    @(posedge clk_6M);
  endtask

  task automatic draw(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      rng = lfsr_next(rng);
      v = {v[62:0], rng[0]};
    end
  endtask

  // flip_mode 0 clean, 1 one bit in a triplet, 2 two bits in a data triplet
  task automatic run_test(input string name, input logic wen, input logic poll,
                          input logic mismatch, input int flip_mode);
    logic [63:0] v;
    logic [63:0] sw;
    logic [9:0]  hdr;
    logic [7:0]  u;
    logic [5:0]  seed;
    int          t;
    int          r;
    test_name = name;
    draw(10, v);
    hdr = v[9:0];
    if (poll)
      hdr[6:3] = 4'd1;
    if (flip_mode == 2)
      hdr[8:7] = ~{prev_arqn, prev_flow};  // differ from the held flow and arqn
    draw(8, v);
    u = v[7:0];
    draw(6, v);
    seed = v[5:0];
    draw(64, sw);
    exp_line = packet_bits(sw, u, seed, wen, hdr);
    next_tick();
    sync_word  <= sw;
    uap        <= u;
    clk_seed   <= seed;
    whiten_en  <= wen;
    tx_lt_addr <= hdr[2:0];
    tx_pk_type <= hdr[6:3];
    tx_flow    <= hdr[7];
    tx_arqn    <= hdr[8];
    tx_seqn    <= hdr[9];
    my_lt_addr <= mismatch ? hdr[2:0] ^ 3'd5 : hdr[2:0];
    tx_start_p <= 1'b1;
    next_tick();
    tx_start_p <= 1'b0;
    tx_check = 1'b1;
    tx_pos = 0;
    for (int i = 0; i < 126; i++)
    begin
      next_tick();
      rec[i] = line_q;
      tx_pos++;
    end
    tx_check = 1'b0;

    flip = '0;
    draw(8, v);
    if (flip_mode == 1)
    begin
      t = int'(v[7:0]) % 18;
      draw(8, v);
      r = int'(v[7:0]) % 3;
      flip[72 + 3*t + r] = 1'b1;
    end
    else if (flip_mode == 2)
    begin
      t = int'(v[7:0]) % 10;
      flip[72 + 3*t] = 1'b1;
      flip[73 + 3*t] = 1'b1;
    end
    exp_hdr   = hdr;
    exp_good  = (flip_mode != 2);
    exp_addr  = exp_good && !mismatch;

    next_tick();
    rx_trailer_st_p <= 1'b1;
    next_tick();
    rx_trailer_st_p <= 1'b0;
    rx_bit <= rec[68] ^ flip[68];
    for (int k = 69; k < 126; k++)
    begin
      next_tick();
      rx_bit <= rec[k] ^ flip[k];
    end
    next_tick();  // count 125 taken
    rx_bit <= 1'b0;
    done_due = 1'b1;
    next_tick();
    done_due = 1'b0;
    if (exp_good)
    begin
      prev_flow = hdr[7];
      prev_arqn = hdr[8];
    end
    tests_run++;
  endtask

  initial
  begin
    rng             = 32'd84973;
    div             = 3'd0;
    cycles          = 0;
    errors          = 0;
    tests_run       = 0;
    tx_check        = 1'b0;
    done_due        = 1'b0;
    tx_pos          = 0;
    exp_line        = '0;
    exp_hdr         = '0;
    exp_good        = 1'b0;
    exp_addr        = 1'b0;
    prev_flow       = 1'b1;
    prev_arqn       = 1'b0;
    test_name       = "reset";
    rstz            = 1'b0;
    p_1us           = 1'b0;
    tx_start_p      = 1'b0;
    rx_trailer_st_p = 1'b0;
    sync_word       = '0;
    uap             = '0;
    clk_seed        = '0;
    whiten_en       = 1'b1;
    tx_lt_addr      = '0;
    tx_pk_type      = '0;
    tx_flow         = 1'b0;
    tx_arqn         = 1'b0;
    tx_seqn         = 1'b0;
    my_lt_addr      = '0;
    rx_bit          = 1'b0;
    repeat (3) @(posedge clk_6M);
    rstz <= 1'b1;

    run_test("clean whitened", 1'b1, 1'b0, 1'b0, 0);
    run_test("clean unwhitened", 1'b0, 1'b0, 1'b0, 0);
    run_test("poll packet", 1'b1, 1'b1, 1'b0, 0);
    run_test("single error", 1'b1, 1'b0, 1'b0, 1);
    run_test("single error unwhitened", 1'b0, 1'b0, 1'b0, 1);
    run_test("double error", 1'b1, 1'b0, 1'b0, 2);
    run_test("other address", 1'b1, 1'b0, 1'b1, 0);
    run_test("clean after error", 1'b1, 1'b0, 1'b0, 0);

    $display("tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== logic/baseband_header.sv ====
`include "bb_defines.svh"

module baseband_header
  import bb_pkg::*;
(
  input  logic         clk_6M,
  input  logic         rstz,
  input  logic         p_1us,
  input  logic         tx_start_p,
  input  logic         rx_trailer_st_p,
  input  sync_word_t   sync_word,
  input  uap_t         uap,
  input  whiten_seed_t clk_seed,
  input  logic         whiten_en,
  input  lt_addr_t     tx_lt_addr,
  input  pk_type_t     tx_pk_type,
  input  logic         tx_flow,
  input  logic         tx_arqn,
  input  logic         tx_seqn,
  input  lt_addr_t     my_lt_addr,
  input  logic         rx_bit,
  output logic         tx_bit,
  output logic         busy,
  output lt_addr_t     rx_lt_addr,
  output pk_type_t     rx_pk_type,
  output logic         rx_flow,
  output logic         rx_arqn,
  output logic         rx_seqn,
  output logic         rx_is_poll,
  output logic         hec_good,
  output logic         lt_addressed,
  output logic         hdr_done_p
);

  seq_phase_e                 seq_phase;
  logic [3:0]                 hdr_index;
  logic                       access_bit;
  logic                       coded_bit;
  logic                       decoded_bit;
  logic                       fec_step_p;
  logic                       header_st_p;
  logic                       hec_end_p;
  logic                       packet_end_p;
  hec_t                       hec_rem;
  logic                       transmit;
  logic                       hdr_tx_bit;
  logic [`BB_HEADER_BITS-1:0] tx_header;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      transmit <= 1'b0;
    else if (p_1us && tx_start_p)
      transmit <= 1'b1;
    else if (p_1us && rx_trailer_st_p)
      transmit <= 1'b0;
    else if (packet_end_p)
      transmit <= 1'b0;  // line goes quiet after the last hec bit
  end

  assign tx_header  = {tx_seqn, tx_arqn, tx_flow, tx_pk_type, tx_lt_addr};
  assign hdr_tx_bit = (hdr_index < `BB_HEADER_BITS) ? tx_header[hdr_index] : 1'b0;

  always_comb
  begin
    if (!transmit)
      tx_bit = 1'b0;
    else if ((seq_phase == ph_header) || (seq_phase == ph_hec))
      tx_bit = coded_bit;
    else
      tx_bit = access_bit;
  end

  packet_sequencer u_seq (
    .clk_6M          (clk_6M),
    .rstz            (rstz),
    .p_1us           (p_1us),
    .tx_start_p      (tx_start_p),
    .rx_trailer_st_p (rx_trailer_st_p),
    .sync_word       (sync_word),
    .access_bit      (access_bit),
    .seq_phase       (seq_phase),
    .hdr_index       (hdr_index),
    .fec_step_p      (fec_step_p),
    .header_st_p     (header_st_p),
    .hec_end_p       (hec_end_p),
    .packet_end_p    (packet_end_p),
    .busy            (busy)
  );

  header_codec u_codec (
    .clk_6M      (clk_6M),
    .rstz        (rstz),
    .p_1us       (p_1us),
    .transmit    (transmit),
    .whiten_en   (whiten_en),
    .uap         (uap),
    .clk_seed    (clk_seed),
    .header_st_p (header_st_p),
    .fec_step_p  (fec_step_p),
    .seq_phase   (seq_phase),
    .hdr_index   (hdr_index),
    .hdr_tx_bit  (hdr_tx_bit),
    .rx_bit      (rx_bit),
    .coded_bit   (coded_bit),
    .decoded_bit (decoded_bit),
    .hec_rem     (hec_rem)
  );

  header_decoder u_dec (
    .clk_6M       (clk_6M),
    .rstz         (rstz),
    .p_1us        (p_1us),
    .transmit     (transmit),
    .decoded_bit  (decoded_bit),
    .fec_step_p   (fec_step_p),
    .hdr_index    (hdr_index),
    .hec_end_p    (hec_end_p),
    .hec_rem      (hec_rem),
    .my_lt_addr   (my_lt_addr),
    .rx_lt_addr   (rx_lt_addr),
    .rx_pk_type   (rx_pk_type),
    .rx_flow      (rx_flow),
    .rx_arqn      (rx_arqn),
    .rx_seqn      (rx_seqn),
    .hec_good     (hec_good),
    .lt_addressed (lt_addressed),
    .rx_is_poll   (rx_is_poll),
    .hdr_done_p   (hdr_done_p)
  );

endmodule

// ==== logic/header_decoder.sv ====
`include "bb_defines.svh"

module header_decoder
  import bb_pkg::*;
(
  input  logic       clk_6M,
  input  logic       rstz,
  input  logic       p_1us,
  input  logic       transmit,
  input  logic       decoded_bit,
  input  logic       fec_step_p,
  input  logic [3:0] hdr_index,
  input  logic       hec_end_p,
  input  hec_t       hec_rem,
  input  lt_addr_t   my_lt_addr,
  output lt_addr_t   rx_lt_addr,
  output pk_type_t   rx_pk_type,
  output logic       rx_flow,
  output logic       rx_arqn,
  output logic       rx_seqn,
  output logic       hec_good,
  output logic       lt_addressed,
  output logic       rx_is_poll,
  output logic       hdr_done_p
);

  localparam pk_type_t poll_type = 4'b0001;

  lt_addr_t lt_sr;
  pk_type_t type_sr;
  logic     flow_sr;
  logic     arqn_sr;
  logic     seqn_sr;
  logic     rx_step;
  logic     rx_end;
  logic     eval_q;
  logic     done_wait;
  logic     rem_zero;

  assign rx_step  = fec_step_p && !transmit && (hdr_index < `BB_HEADER_BITS);
  assign rx_end   = hec_end_p && !transmit;
  assign rem_zero = (hec_rem == '0);

  // fields arrive lsb first
  always_ff @(posedge clk_6M)
  begin
    if (rx_step)
    begin
      if (hdr_index < 4'd3)
        lt_sr <= {decoded_bit, lt_sr[2:1]};
      else if (hdr_index < 4'd7)
        type_sr <= {decoded_bit, type_sr[3:1]};
      else if (hdr_index == 4'd7)
        flow_sr <= decoded_bit;
      else if (hdr_index == 4'd8)
        arqn_sr <= decoded_bit;
      else
        seqn_sr <= decoded_bit;
    end
  end

  // remainder settles the cycle after hec_end_p, done goes out on the next tick
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      eval_q    <= 1'b0;
      done_wait <= 1'b0;
    end
    else
    begin
      eval_q <= rx_end;
      if (rx_end)
        done_wait <= 1'b1;
      else if (p_1us)
        done_wait <= 1'b0;
    end
  end

  assign hdr_done_p = done_wait && p_1us;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      rx_lt_addr   <= '0;
      rx_pk_type   <= '0;
      rx_seqn      <= 1'b0;
      rx_flow      <= 1'b1;  // go
      rx_arqn      <= 1'b0;
      hec_good     <= 1'b0;
      lt_addressed <= 1'b0;
    end
    else if (eval_q)
    begin
      rx_lt_addr   <= lt_sr;
      rx_pk_type   <= type_sr;
      rx_seqn      <= seqn_sr;
      hec_good     <= rem_zero;
      lt_addressed <= rem_zero && (lt_sr == my_lt_addr);
      if (rem_zero)
      begin
        rx_flow <= flow_sr;
        rx_arqn <= arqn_sr;
      end
    end
    else if (transmit || (rx_step && (hdr_index == 4'd0)))
      lt_addressed <= 1'b0;  // new packet under way
  end

  assign rx_is_poll = (rx_pk_type == poll_type);

endmodule

// ==== logic/header_codec.sv ====
`include "bb_defines.svh"

module header_codec
  import bb_pkg::*;
(
  input  logic         clk_6M,
  input  logic         rstz,
  input  logic         p_1us,
  input  logic         transmit,
  input  logic         whiten_en,
  input  uap_t         uap,
  input  whiten_seed_t clk_seed,
  input  logic         header_st_p,
  input  logic         fec_step_p,
  input  seq_phase_e   seq_phase,
  input  logic [3:0]   hdr_index,
  input  logic         hdr_tx_bit,
  input  logic         rx_bit,
  output logic         coded_bit,
  output logic         decoded_bit,
  output hec_t         hec_rem
);

  localparam logic [8:0] hec_gen    = `BB_HEC_POLY;
  localparam logic [7:0] whiten_gen = `BB_WHITEN_POLY;

  logic [6:0] whiten;
  logic [1:0] rx_sr;
  logic       hdr_phase;
  logic       white_bit;
  logic       tx_plain;
  logic       majority;
  logic       hec_in;
  logic       hec_fb;

  assign hdr_phase = (seq_phase == ph_header) || (seq_phase == ph_hec);
  assign white_bit = whiten_en & whiten[6];

  // past bit 9 the remainder shifts out msb first
  assign tx_plain  = (hdr_index < `BB_HEADER_BITS) ? hdr_tx_bit : hec_rem[7];
  // state only moves on fec_step_p, so each bit is held for its triplet
  assign coded_bit = tx_plain ^ white_bit;

  // first two samples of the triplet, third one is rx_bit itself
  always_ff @(posedge clk_6M)
  begin
    if (p_1us && hdr_phase)
      rx_sr <= {rx_sr[0], rx_bit};
  end

  assign majority = (rx_sr[1] & rx_sr[0]) | (rx_sr[1] & rx_bit) | (rx_sr[0] & rx_bit);
  assign decoded_bit = majority ^ white_bit;

  // on tx the hec bits feed back zero, on rx a good hec cancels the remainder
  assign hec_in = transmit ? tx_plain : decoded_bit;
  assign hec_fb = hec_rem[7] ^ hec_in;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      hec_rem <= '0;
    else if (header_st_p)
      hec_rem <= uap;
    else if (fec_step_p)
      hec_rem <= {hec_rem[6:0], 1'b0} ^ (hec_fb ? hec_gen[7:0] : 8'h00);
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      whiten <= '1;
    else if (header_st_p)
      whiten <= {1'b1, clk_seed};  // top bit forced so it never locks up
    else if (fec_step_p)
      whiten <= {whiten[5:0], 1'b0} ^ (whiten[6] ? whiten_gen[6:0] : 7'h00);
  end

  assert property (@(posedge clk_6M) disable iff (!rstz)
    hdr_phase |-> (whiten != '0))
    else $error("whitener stuck at zero during header");

endmodule

// ==== logic/packet_sequencer.sv ====
`include "bb_defines.svh"

module packet_sequencer
  import bb_pkg::*;
(
  input  logic       clk_6M,
  input  logic       rstz,
  input  logic       p_1us,
  input  logic       tx_start_p,
  input  logic       rx_trailer_st_p,
  input  sync_word_t sync_word,
  output logic       access_bit,
  output seq_phase_e seq_phase,
  output logic [3:0] hdr_index,
  output logic       fec_step_p,
  output logic       header_st_p,
  output logic       hec_end_p,
  output logic       packet_end_p,
  output logic       busy
);

  localparam logic [1:0] fec_last = 2'(`BB_FEC_REPEAT - 1);

  bit_count_t bit_count;
  logic [1:0] fec_cnt;
  logic [5:0] sync_idx;
  logic       hdr_phase;
  logic       last_bit;

  assign last_bit = busy && (bit_count == `BB_PACKET_END);

  // a start strobe always wins, even mid packet
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      bit_count <= '0;
      busy      <= 1'b0;
    end
    else if (p_1us)
    begin
      if (tx_start_p)
      begin
        bit_count <= '0;
        busy      <= 1'b1;
      end
      else if (rx_trailer_st_p)
      begin
        bit_count <= `BB_RX_TRAILER_START;
        busy      <= 1'b1;
      end
      else if (last_bit)
        busy <= 1'b0;  // count parks on 125
      else if (busy)
        bit_count <= bit_count + 8'd1;
    end
  end

  always_comb
  begin
    if (!busy)
      seq_phase = ph_idle;
    else if (bit_count <= `BB_PREAMBLE_END)
      seq_phase = ph_preamble;
    else if (bit_count <= `BB_SYNC_END)
      seq_phase = ph_sync;
    else if (bit_count <= `BB_TRAILER_END)
      seq_phase = ph_trailer;
    else if (bit_count <= `BB_HEADER_END)
      seq_phase = ph_header;
    else
      seq_phase = ph_hec;
  end

  assign hdr_phase = (seq_phase == ph_header) || (seq_phase == ph_hec);

  // counts 4..67 map onto sync bits 0..63
  assign sync_idx = 6'(bit_count - `BB_PREAMBLE_END - 8'd1);

  // preamble and trailer keep alternating into and out of the sync word
  always_comb
  begin
    case (seq_phase)
      ph_preamble: access_bit = sync_word[0] ^ bit_count[0];
      ph_sync:     access_bit = sync_word[sync_idx];
      ph_trailer:  access_bit = sync_word[63] ^ ~bit_count[0];
      default:     access_bit = 1'b0;
    endcase
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      fec_cnt <= '0;
    else if (!hdr_phase)
      fec_cnt <= '0;
    else if (p_1us)
      fec_cnt <= (fec_cnt == fec_last) ? 2'd0 : fec_cnt + 2'd1;
  end

  assign fec_step_p   = hdr_phase && p_1us && (fec_cnt == fec_last);
  assign header_st_p  = busy && p_1us && (bit_count == `BB_TRAILER_END);
  assign hec_end_p    = p_1us && (seq_phase == ph_hec) && (bit_count == `BB_PACKET_END);
  assign packet_end_p = p_1us && last_bit;

  // header bits 0..9, then parked at 10 while the hec goes through
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      hdr_index <= '0;
    else if (header_st_p)
      hdr_index <= '0;
    else if (fec_step_p && (hdr_index < `BB_HEADER_BITS))
      hdr_index <= hdr_index + 4'd1;
  end

  // triplet counter has to stay in step with the bit count
  assert property (@(posedge clk_6M) disable iff (!rstz)
    fec_step_p |-> hdr_phase && ((bit_count - `BB_HEADER_START) % 8'd3 == 8'd2))
    else $error("fec_step_p off the triplet grid at count %0d", bit_count);

endmodule

// ==== logic/bb_pkg.sv ====
package bb_pkg;

  typedef logic [2:0]  lt_addr_t;
  typedef logic [3:0]  pk_type_t;
  typedef logic [7:0]  uap_t;          // hec seed
  typedef logic [7:0]  hec_t;
  typedef logic [63:0] sync_word_t;    // bit 0 goes out first
  typedef logic [7:0]  bit_count_t;
  typedef logic [5:0]  whiten_seed_t;  // clk[6:1]

  typedef enum logic [2:0] {
    ph_idle,
    ph_preamble,
    ph_sync,
    ph_trailer,
    ph_header,
    ph_hec
  } seq_phase_e;

endpackage

// ==== logic/bb_defines.svh ====
`ifndef BB_DEFINES_SVH
`define BB_DEFINES_SVH

// bit count boundaries, last count of each field
`define BB_PREAMBLE_END      8'd3
`define BB_SYNC_END          8'd67
`define BB_TRAILER_END       8'd71
`define BB_HEADER_END        8'd101
`define BB_PACKET_END        8'd125

`define BB_HEADER_START      8'd72
`define BB_RX_TRAILER_START  8'd68  // correlator hands over here

// field lengths
`define BB_HEADER_BITS       4'd10  // lt_addr, type, flow, arqn, seqn
`define BB_FEC_REPEAT        3      // rate 1/3 repetition

// D8 + D7 + D5 + D2 + D + 1
`define BB_HEC_POLY          9'h1a7

// D7 + D4 + 1
`define BB_WHITEN_POLY       8'h91

`endif
